//--- Makefile
# Verilator build and run for the ps pio channel testbench

VERILATOR ?= verilator
TOP       ?= ps_pio_tb
FLIST     ?= ps_pio_channel.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard verilog/*.sv verilog/*.svh dv/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- dv/ps_pio_props.sv
// concurrent checks on arbiter request rules and grant to sequencer timing
module ps_pio_props (
    input logic rst,
    input logic mclk,
    input logic want_rq0,
    input logic need_rq0,
    input logic want_rq1,
    input logic need_rq1,
    input logic grant,
    input logic chn_rst,
    input logic seq_set
);
    // one channel at a time
    a_one_channel: assert property (@(posedge rst) disable iff (!mclk)
        !((want_rq0 || need_rq0) && (want_rq1 || need_rq1)))
        else $error("requests raised on both channels");

    a_need0_want: assert property (@(posedge rst) disable iff (!mclk)
        need_rq0 |-> want_rq0)
        else $error("need_rq0 without want_rq0");

    a_need1_want: assert property (@(posedge rst) disable iff (!mclk)
        need_rq1 |-> want_rq1)
        else $error("need_rq1 without want_rq1");

    // grant drops all requests, sequencer loads next cycle
    a_grant_seq: assert property (@(posedge rst) disable iff (!mclk)
        (grant && !chn_rst) |=> seq_set && !(want_rq0 || need_rq0 || want_rq1 || need_rq1))
        else $error("grant not followed by seq_set with requests dropped");
endmodule

//--- dv/ps_pio_tb.sv
// testbench for the ps pio channel, LFSR stimulus checked against a command and buffer model
`include "ps_pio_defs.svh"

module ps_pio_tb;
    localparam int TIMEOUT = 200;              // cycles allowed per wait

    logic                  rst;                // clock
    logic                  mclk;               // reset, active low
    logic [7:0]            cmd_ad;
    logic                  cmd_stb;
    logic [7:0]            status_ad;
    logic                  status_rq;
    logic                  status_start;
    logic                  port0_re;
    ps_pio_pkg::buf_addr_t port0_addr;
    ps_pio_pkg::buf_data_t port0_data;
    logic                  port1_we;
    ps_pio_pkg::buf_addr_t port1_addr;
    ps_pio_pkg::buf_data_t port1_data;
    logic                  want_rq0;
    logic                  need_rq0;
    logic                  channel_pgm_en0;
    logic                  seq_done0;
    logic                  buf_wr_chn0;
    logic                  buf_wpage_nxt_chn0;
    ps_pio_pkg::buf_data_t buf_wdata_chn0;
    logic                  want_rq1;
    logic                  need_rq1;
    logic                  channel_pgm_en1;
    logic                  seq_done1;
    logic                  rpage_nxt_chn1;
    logic                  buf_rd_chn1;
    ps_pio_pkg::buf_data_t buf_rdata_chn1;
    ps_pio_pkg::seq_addr_t seq_data;
    logic                  seq_set;

    ps_pio_pkg::ps_cmd_t   cmd_q [$];          // expected fifo contents
    logic [1:0]            en_model;           // expected enable/reset bits
    logic                  busy_model;         // granted command not yet done
    logic [15:0]           lfsr;

    ps_pio_channel UUT (.*);

    bind ps_request_ctrl ps_pio_props props_i (
        .rst      (rst),
        .mclk     (mclk),
        .want_rq0 (want_rq0),
        .need_rq0 (need_rq0),
        .want_rq1 (want_rq1),
        .need_rq1 (need_rq1),
        .grant    (grant),
        .chn_rst  (chn_rst),
        .seq_set  (seq_set)
    );

    always #10 rst = ~rst;

    // taps 16 14 13 11
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v    = {v[30:0], lfsr[0]};         // one step per bit
        end
        return v;
    endfunction

    function automatic ps_pio_pkg::ps_cmd_t rand_cmd();
        return 14'(rand_bits(14));             // chn, need, page, seq addr
    endfunction

    function automatic ps_pio_pkg::status_t model_status();
        return {cmd_q.size() >= `PS_CMD_FIFO_DEPTH / 2, cmd_q.size() != 0 || busy_model};
    endfunction

    task automatic abort_run;
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_seq(input string name, input ps_pio_pkg::seq_addr_t got,
                             input ps_pio_pkg::seq_addr_t exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input ps_pio_pkg::buf_data_t got,
                              input ps_pio_pkg::buf_data_t exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_status(input string name, input logic [7:0] got,
                                input logic [7:0] exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    // six bytes: addr lo, addr hi, data 0..3
    task automatic host_write(input logic [15:0] addr, input ps_pio_pkg::reg_data_t data);
        logic [47:0] bytes;
        bytes = {data, addr};
        for (int i = 0; i < `PS_CMD_BYTES; i++) begin
            @(negedge rst);
            cmd_ad  = bytes[8*i +: 8];
            cmd_stb = (i == 0);
        end
        @(negedge rst);
        cmd_ad = 8'h00;                        // cmd_we in this cycle
        @(negedge rst);                        // register updated
    endtask

    task automatic reg_write(input ps_pio_pkg::reg_addr_t idx,
                             input ps_pio_pkg::reg_data_t data);
        host_write({6'(rand_bits(6)), 5'b01000, idx}, data);   // bits 9..5 hit the base
    endtask

    task automatic set_enable(input logic [1:0] v);
        reg_write(5'(`PS_REG_EN_RST), 32'(v));
        en_model = v;
        if (!v[0])
            cmd_q.delete();                    // reset flushes the fifo
    endtask

    task automatic push_cmd(input ps_pio_pkg::ps_cmd_t c);
        reg_write(5'(`PS_REG_CMD), 32'(c));
        if (en_model[0] && cmd_q.size() < `PS_CMD_FIFO_DEPTH)
            cmd_q.push_back(c);                // full fifo drops it
    endtask

    task automatic expect_quiet(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge rst);
            check_flag("want_rq0", want_rq0, 1'b0);
            check_flag("need_rq0", need_rq0, 1'b0);
            check_flag("want_rq1", want_rq1, 1'b0);
            check_flag("need_rq1", need_rq1, 1'b0);
        end
    endtask

    task automatic wait_request(input logic chn);
        int n;
        n = 0;
        while ((chn ? want_rq1 : want_rq0) !== 1'b1 && n < TIMEOUT) begin
            n++;
            @(negedge rst);
        end
        if (n >= TIMEOUT) begin
            $display("timeout, no request raised on channel %0d", chn);
            abort_run();
        end
    endtask

    task automatic wait_status_rq;
        int n;
        n = 0;
        while (status_rq !== 1'b1 && n < TIMEOUT) begin
            n++;
            @(negedge rst);
        end
        if (n >= TIMEOUT) begin
            $display("timeout, no status message was requested");
            abort_run();
        end
    endtask

    task automatic status_read(input logic [5:0] sq, input ps_pio_pkg::status_t pay);
        wait_status_rq();
        check_status("status_ad", status_ad, `PS_STATUS_REG_ADDR);
        status_start = 1'b1;
        @(negedge rst);
        status_start = 1'b0;
        check_flag("status_rq", status_rq, 1'b0);
        check_status("status_ad", status_ad, {sq, pay});   // seq number and payload
        @(negedge rst);
        check_status("status_ad", status_ad, 8'h00);
    endtask

    // memory writes four words, page-next, two more, then host reads all back
    task automatic chn0_transfer(input ps_pio_pkg::page_t pg);
        ps_pio_pkg::buf_addr_t addrs [$];
        ps_pio_pkg::buf_data_t words [$];
        ps_pio_pkg::page_t     cur;
        cur = pg;
        for (int k = 0; k < 6; k++) begin
            if (k == 4) begin
                buf_wr_chn0        = 1'b0;
                buf_wpage_nxt_chn0 = 1'b1;
                @(negedge rst);
                buf_wpage_nxt_chn0 = 1'b0;
                cur                = cur + 2'd1;   // wraps past page 3
            end
            addrs.push_back({cur, 8'(k % 4)});
            buf_wdata_chn0 = rand_bits(32);
            words.push_back(buf_wdata_chn0);
            buf_wr_chn0 = 1'b1;
            @(negedge rst);
        end
        buf_wr_chn0 = 1'b0;
        for (int k = 0; k < 6; k++) begin
            port0_addr = addrs[k];
            port0_re   = 1'b1;
            @(negedge rst);
            port0_re = 1'b0;
            check_word("port0_data", port0_data, words[k]);
        end
    endtask

    // host fills the page, memory side reads it back in counter order
    task automatic chn1_transfer(input ps_pio_pkg::page_t pg);
        ps_pio_pkg::buf_data_t words [$];
        for (int k = 0; k < 4; k++) begin
            port1_addr = {pg, 8'(k)};
            port1_data = rand_bits(32);
            words.push_back(port1_data);
            port1_we = 1'b1;
            @(negedge rst);
        end
        port1_we = 1'b0;
        for (int k = 0; k < 4; k++) begin
            buf_rd_chn1 = 1'b1;
            @(negedge rst);
            buf_rd_chn1 = 1'b0;
            check_word("buf_rdata_chn1", buf_rdata_chn1, words[k]);
        end
    endtask

    task automatic serve_next;
        ps_pio_pkg::ps_cmd_t c;
        logic [5:0]          sq;
        c = cmd_q.pop_front();
        wait_request(c[13]);
        check_flag("want_rq0", want_rq0, !c[13]);
        check_flag("need_rq0", need_rq0, !c[13] && c[12]);
        check_flag("want_rq1", want_rq1, c[13]);
        check_flag("need_rq1", need_rq1, c[13] && c[12]);
        channel_pgm_en0 = !c[13];              // single-cycle grant
        channel_pgm_en1 = c[13];
        @(negedge rst);
        channel_pgm_en0 = 1'b0;
        channel_pgm_en1 = 1'b0;
        busy_model      = 1'b1;
        check_flag("seq_set", seq_set, 1'b1);
        check_seq("seq_data", seq_data, c[9:0]);
        check_flag("want_rq0", want_rq0, 1'b0);
        check_flag("want_rq1", want_rq1, 1'b0);
        @(negedge rst);                        // page_set cycle
        @(negedge rst);
        if (c[13])
            chn1_transfer(c[11:10]);
        else
            chn0_transfer(c[11:10]);
        if (cmd_q.size() == 0) begin           // busy alone holds status bit 0
            sq = 6'(rand_bits(6));
            reg_write(5'(`PS_REG_STATUS_CNTRL), 32'({2'b01, sq}));
            status_read(sq, model_status());
        end
        check_flag("want_rq0", want_rq0, 1'b0);   // held off while mem_run
        check_flag("want_rq1", want_rq1, 1'b0);
        seq_done0 = !c[13];
        seq_done1 = c[13];
        @(negedge rst);
        seq_done0  = 1'b0;
        seq_done1  = 1'b0;
        busy_model = 1'b0;
    endtask

    initial begin
        logic [5:0] sq;
        int         k;
        rst                = 1'b0;
        mclk               = 1'b0;
        cmd_ad             = 8'h00;
        cmd_stb            = 1'b0;
        status_start       = 1'b0;
        port0_re           = 1'b0;
        port0_addr         = '0;
        port1_we           = 1'b0;
        port1_addr         = '0;
        port1_data         = '0;
        channel_pgm_en0    = 1'b0;
        seq_done0          = 1'b0;
        buf_wr_chn0        = 1'b0;
        buf_wpage_nxt_chn0 = 1'b0;
        buf_wdata_chn0     = '0;
        channel_pgm_en1    = 1'b0;
        seq_done1          = 1'b0;
        rpage_nxt_chn1     = 1'b0;
        buf_rd_chn1        = 1'b0;
        en_model           = 2'b00;
        busy_model         = 1'b0;
        lfsr               = 16'd71;
        repeat (16) @(negedge rst);
        mclk = 1'b1;
        @(negedge rst);
        check_flag("seq_set", seq_set, 1'b0);
        check_flag("status_rq", status_rq, 1'b0);
        expect_quiet(2);

        // writes that must not raise requests
        push_cmd(rand_cmd());                  // held in reset
        expect_quiet(20);
        set_enable(2'b11);
        host_write({6'(rand_bits(6)), 5'b10001, 5'(`PS_REG_CMD)}, 32'(rand_cmd()));
        expect_quiet(20);
        set_enable(2'b01);
        push_cmd(rand_cmd());                  // queued but not enabled
        expect_quiet(20);
        set_enable(2'b00);

        // status single shot with a few queued commands
        set_enable(2'b01);
        k = int'(rand_bits(2));
        for (int i = 0; i < k; i++)
            push_cmd(rand_cmd());
        sq = 6'(rand_bits(6));
        reg_write(5'(`PS_REG_STATUS_CNTRL), 32'({2'b01, sq}));
        status_read(sq, model_status());

        // auto mode, one message per payload change
        set_enable(2'b00);
        set_enable(2'b01);
        sq = 6'(rand_bits(6));
        reg_write(5'(`PS_REG_STATUS_CNTRL), 32'({2'b11, sq}));
        status_read(sq, model_status());
        for (int i = 0; i < 2; i++) begin
            push_cmd(rand_cmd());
            status_read(sq, model_status());
        end
        set_enable(2'b00);
        status_read(sq, model_status());
        reg_write(5'(`PS_REG_STATUS_CNTRL), 32'h0);

        // random commands served in order
        set_enable(2'b11);
        for (int r = 0; r < 4; r++) begin
            for (int i = 0; i < 3; i++)
                push_cmd(rand_cmd());
            while (cmd_q.size() > 0)
                serve_next();
        end

        // overflow, extras dropped
        for (int i = 0; i < 6; i++)
            push_cmd(rand_cmd());
        while (cmd_q.size() > 0)
            serve_next();
        expect_quiet(20);

        $display("SIMULATION PASSED");
        $finish;
    end
endmodule

//--- ps_pio_channel.f
+incdir+verilog
verilog/ps_pio_pkg.sv
verilog/cmd_deser.sv
verilog/cmd_fifo.sv
verilog/ps_request_ctrl.sv
verilog/status_gen.sv
verilog/ps_rd_buffer.sv
verilog/ps_wr_buffer.sv
verilog/ps_pio_channel.sv
dv/ps_pio_props.sv
dv/ps_pio_tb.sv

//--- verilog/cmd_deser.sv
// byte-serial command deserializer, six bytes into register index, data and write strobe
`include "ps_pio_defs.svh"

module cmd_deser (
    input  logic                  rst,
    input  logic                  mclk,
    input  logic [7:0]            ad,
    input  logic                  stb,
    output ps_pio_pkg::reg_addr_t addr,
    output ps_pio_pkg::reg_data_t data,
    output logic                  we
);
    localparam int SR_W = 8 * `PS_CMD_BYTES;
    localparam int CW   = $clog2(`PS_CMD_BYTES);

    logic [SR_W-1:0] sr;       // bytes enter at the top
    logic [CW-1:0]   cnt;      // bytes taken, 0 when idle
    logic            last;     // sixth byte on ad
    logic            addr_hit;

    assign last = (cnt == CW'(`PS_CMD_BYTES - 1));
    // on the last byte the two address bytes sit just above byte 5's slot
    assign addr_hit = ((sr[23:8] & `PS_ADDR_MASK) == (`PS_BASE_ADDR & `PS_ADDR_MASK));

    always_ff @(posedge rst or negedge mclk) begin
        if (!mclk) begin
            cnt <= '0;
            we  <= 1'b0;
        end else begin
            we <= last && addr_hit;                // one cycle after sixth byte
            if (stb)
                cnt <= CW'(1);                     // first byte with stb
            else if (last)
                cnt <= '0;
            else if (cnt != '0)
                cnt <= cnt + CW'(1);
        end
    end

    always_ff @(posedge rst) begin
        if (stb || (cnt != '0))
            sr <= {ad, sr[SR_W-1:8]};              // holds once idle
    end

    assign addr = sr[4:0];                         // register index only
    assign data = sr[SR_W-1:16];
endmodule

//--- verilog/cmd_fifo.sv
// same-clock register FIFO with synchronous flush, full and half-full flags
module cmd_fifo #(
    parameter int WIDTH = 14,
    parameter int DEPTH = 4
) (
    input  logic             rst,
    input  logic             mclk,
    input  logic             flush,
    input  logic             we,
    input  logic             re,
    input  logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout,
    output logic             nempty,
    output logic             full,
    output logic             half_full
);
    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wptr;
    logic [AW-1:0]    rptr;
    logic [CW-1:0]    count;     // words held
    logic             push;
    logic             pop;

    assign push      = we && !full;            // overflow drops the word
    assign pop       = re && nempty;
    assign nempty    = (count != '0);
    assign full      = (count == CW'(DEPTH));
    assign half_full = (count >= CW'(DEPTH / 2));
    assign dout      = mem[rptr];              // head visible before pop

    always_ff @(posedge rst or negedge mclk) begin
        if (!mclk) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else if (flush) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (push)
                wptr <= wptr + AW'(1);         // wraps, depth is 2**n
            if (pop)
                rptr <= rptr + AW'(1);
            case ({push, pop})
                2'b10:   count <= count + CW'(1);
                2'b01:   count <= count - CW'(1);
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge rst) begin
        if (push)
            mem[wptr] <= din;
    end
endmodule

//--- verilog/ps_pio_channel.sv
// ps pio memory access channel top, command deserializer through page buffers
module ps_pio_channel (
    input  logic                  rst,
    input  logic                  mclk,
    input  logic [7:0]            cmd_ad,
    input  logic                  cmd_stb,
    output logic [7:0]            status_ad,
    output logic                  status_rq,
    input  logic                  status_start,
    input  logic                  port0_re,
    input  ps_pio_pkg::buf_addr_t port0_addr,
    output ps_pio_pkg::buf_data_t port0_data,
    input  logic                  port1_we,
    input  ps_pio_pkg::buf_addr_t port1_addr,
    input  ps_pio_pkg::buf_data_t port1_data,
    output logic                  want_rq0,
    output logic                  need_rq0,
    input  logic                  channel_pgm_en0,
    input  logic                  seq_done0,
    input  logic                  buf_wr_chn0,
    input  logic                  buf_wpage_nxt_chn0,
    input  ps_pio_pkg::buf_data_t buf_wdata_chn0,
    output logic                  want_rq1,
    output logic                  need_rq1,
    input  logic                  channel_pgm_en1,
    input  logic                  seq_done1,
    input  logic                  rpage_nxt_chn1,
    input  logic                  buf_rd_chn1,
    output ps_pio_pkg::buf_data_t buf_rdata_chn1,
    output ps_pio_pkg::seq_addr_t seq_data,
    output logic                  seq_set
);
    ps_pio_pkg::reg_addr_t cmd_a;
    ps_pio_pkg::reg_data_t cmd_data;
    logic                  cmd_we;
    ps_pio_pkg::page_t     page;           // shared page for both buffers
    logic                  page_set0;
    logic                  page_set1;
    logic                  status_ctl_we;
    ps_pio_pkg::status_t   status;

    cmd_deser cmd_deser_i (
        .rst  (rst),
        .mclk (mclk),
        .ad   (cmd_ad),
        .stb  (cmd_stb),
        .addr (cmd_a),
        .data (cmd_data),
        .we   (cmd_we)
    );

    ps_request_ctrl ps_request_ctrl_i (
        .rst             (rst),
        .mclk            (mclk),
        .cmd_a           (cmd_a),
        .cmd_data        (cmd_data),
        .cmd_we          (cmd_we),
        .channel_pgm_en0 (channel_pgm_en0),
        .channel_pgm_en1 (channel_pgm_en1),
        .seq_done0       (seq_done0),
        .seq_done1       (seq_done1),
        .want_rq0        (want_rq0),
        .need_rq0        (need_rq0),
        .want_rq1        (want_rq1),
        .need_rq1        (need_rq1),
        .seq_data        (seq_data),
        .seq_set         (seq_set),
        .page            (page),
        .page_set0       (page_set0),
        .page_set1       (page_set1),
        .status_ctl_we   (status_ctl_we),
        .status          (status)
    );

    status_gen status_gen_i (
        .rst    (rst),
        .mclk   (mclk),
        .we     (status_ctl_we),
        .wd     (cmd_data[7:0]),           // mode and sequence number
        .status (status),
        .ad     (status_ad),
        .rq     (status_rq),
        .start  (status_start)
    );

    ps_rd_buffer chn0_buf_i (
        .rst       (rst),
        .mclk      (mclk),
        .host_addr (port0_addr),
        .host_re   (port0_re),
        .host_data (port0_data),
        .page_in   (page),
        .page_set  (page_set0),
        .page_next (buf_wpage_nxt_chn0),
        .we        (buf_wr_chn0),
        .wdata     (buf_wdata_chn0)
    );

    ps_wr_buffer chn1_buf_i (
        .rst       (rst),
        .mclk      (mclk),
        .host_addr (port1_addr),
        .host_we   (port1_we),
        .host_data (port1_data),
        .page_in   (page),
        .page_set  (page_set1),
        .page_next (rpage_nxt_chn1),
        .rd        (buf_rd_chn1),
        .rdata     (buf_rdata_chn1)
    );
endmodule

//--- verilog/ps_pio_defs.svh
// ps pio channel register map, address decode and width constants
`ifndef PS_PIO_DEFS_SVH
`define PS_PIO_DEFS_SVH

// address decode on the 16-bit host address
`define PS_BASE_ADDR         16'h0100  // channel base
`define PS_ADDR_MASK         16'h03e0  // bits compared against base

// register indices, low 5 bits of the address
`define PS_REG_EN_RST        0         // enable / reset bits
`define PS_REG_CMD           1         // command word into fifo
`define PS_REG_STATUS_CNTRL  2         // status mode and sequence

`define PS_STATUS_REG_ADDR   8'h02     // first byte of a status message

`define PS_CMD_BYTES         6         // AL AH D0 D1 D2 D3
`define PS_CMD_FIFO_DEPTH    4         // power of two
`define PS_CMD_WIDTH         14        // seq addr + page + need + chn

`endif

//--- verilog/ps_pio_pkg.sv
// shared vector types and status FSM encoding for the ps pio channel
package ps_pio_pkg;

    typedef logic [4:0]  reg_addr_t;   // register index
    typedef logic [31:0] reg_data_t;   // register write data
    typedef logic [9:0]  seq_addr_t;   // sequencer program address
    typedef logic [1:0]  page_t;       // buffer page
    typedef logic [9:0]  buf_addr_t;   // {page, word}
    typedef logic [31:0] buf_data_t;   // buffer word

    // [13] chn, [12] need, [11:10] page, [9:0] seq addr
    typedef logic [13:0] ps_cmd_t;

    // [1] fifo half full, [0] fifo not empty or busy
    typedef logic [1:0]  status_t;

    typedef enum logic [1:0] {ST_IDLE, ST_ADDR, ST_PAYLOAD} status_state_t;

endpackage

//--- verilog/ps_rd_buffer.sv
// four-page read buffer, memory side writes by page counter, host reads by address
module ps_rd_buffer (
    input  logic                  rst,
    input  logic                  mclk,
    input  ps_pio_pkg::buf_addr_t host_addr,
    input  logic                  host_re,
    output ps_pio_pkg::buf_data_t host_data,
    input  ps_pio_pkg::page_t     page_in,
    input  logic                  page_set,
    input  logic                  page_next,
    input  logic                  we,
    input  ps_pio_pkg::buf_data_t wdata
);
    ps_pio_pkg::buf_data_t mem [1024];
    ps_pio_pkg::page_t     page;      // current memory-side page
    logic [7:0]            word;      // word within page

    always_ff @(posedge rst or negedge mclk) begin
        if (!mclk) begin
            page <= '0;
            word <= '0;
        end else if (page_set) begin
            page <= page_in;
            word <= '0;
        end else if (page_next) begin
            page <= page + 2'd1;
            word <= '0;
        end else if (we) begin
            word <= word + 8'd1;
        end
    end

    always_ff @(posedge rst) begin
        if (we)
            mem[{page, word}] <= wdata;
        if (host_re)
            host_data <= mem[host_addr];  // one cycle after re
    end
endmodule

//--- verilog/ps_request_ctrl.sv
// register decode, command queue, arbiter requests and grant sequencing for the channel
`include "ps_pio_defs.svh"

module ps_request_ctrl (
    input  logic                  rst,
    input  logic                  mclk,
    input  ps_pio_pkg::reg_addr_t cmd_a,
    input  ps_pio_pkg::reg_data_t cmd_data,
    input  logic                  cmd_we,
    input  logic                  channel_pgm_en0,
    input  logic                  channel_pgm_en1,
    input  logic                  seq_done0,
    input  logic                  seq_done1,
    output logic                  want_rq0,
    output logic                  need_rq0,
    output logic                  want_rq1,
    output logic                  need_rq1,
    output ps_pio_pkg::seq_addr_t seq_data,
    output logic                  seq_set,
    output ps_pio_pkg::page_t     page,
    output logic                  page_set0,
    output logic                  page_set1,
    output logic                  status_ctl_we,
    output ps_pio_pkg::status_t   status
);
    logic [1:0]          en_reset;      // [0] out of reset, [1] requests enabled
    logic                chn_rst;
    logic                chn_en;
    logic                set_en_rst;
    logic                set_cmd;
    logic                grant;
    logic                seq_done;
    logic                mem_run;       // granted, waiting for sequencer done
    logic                busy;
    logic                start;
    ps_pio_pkg::ps_cmd_t cmd_out;       // fifo head
    logic                cmd_nempty;
    logic                cmd_full;
    logic                cmd_half_full;
    logic                cmd_need;
    logic                cmd_chn;

    assign set_en_rst    = cmd_we && (cmd_a == ps_pio_pkg::reg_addr_t'(`PS_REG_EN_RST));
    assign set_cmd       = cmd_we && (cmd_a == ps_pio_pkg::reg_addr_t'(`PS_REG_CMD));
    assign status_ctl_we = cmd_we && (cmd_a == ps_pio_pkg::reg_addr_t'(`PS_REG_STATUS_CNTRL));

    assign chn_rst  = !en_reset[0];                // also flushes the fifo
    assign chn_en   = en_reset[1];
    assign grant    = channel_pgm_en0 || channel_pgm_en1;
    assign seq_done = seq_done0 || seq_done1;
    assign busy     = want_rq0 || need_rq0 || want_rq1 || need_rq1 || mem_run;
    assign start    = chn_en && !busy && cmd_nempty;

    assign cmd_need = cmd_out[12];
    assign cmd_chn  = cmd_out[13];
    assign seq_data = cmd_out[9:0];                // valid with seq_set
    assign status   = {cmd_half_full, cmd_nempty || busy};

    always_ff @(posedge rst or negedge mclk) begin
        if (!mclk) begin
            en_reset <= 2'b00;                     // held in reset, disabled
            want_rq0 <= 1'b0;
            need_rq0 <= 1'b0;
            want_rq1 <= 1'b0;
            need_rq1 <= 1'b0;
        end else begin
            if (set_en_rst)
                en_reset <= cmd_data[1:0];
            if (chn_rst || grant) begin
                want_rq0 <= 1'b0;
                need_rq0 <= 1'b0;
                want_rq1 <= 1'b0;
                need_rq1 <= 1'b0;
            end else if (start) begin              // one request per queued command
                want_rq0 <= !cmd_chn;
                need_rq0 <= !cmd_chn && cmd_need;
                want_rq1 <= cmd_chn;
                need_rq1 <= cmd_chn && cmd_need;
            end
        end
    end

    always_ff @(posedge rst or negedge mclk) begin
        if (!mclk) begin
            mem_run   <= 1'b0;
            seq_set   <= 1'b0;
            page      <= '0;
            page_set0 <= 1'b0;
            page_set1 <= 1'b0;
        end else begin
            if (chn_rst || seq_done)
                mem_run <= 1'b0;
            else if (grant)
                mem_run <= 1'b1;
            seq_set   <= grant && !chn_rst;        // pops the fifo too
            if (seq_set)
                page <= cmd_out[11:10];
            page_set0 <= seq_set && !cmd_chn;      // to the read buffer
            page_set1 <= seq_set && cmd_chn;       // to the write buffer
        end
    end

    cmd_fifo #(
        .WIDTH (`PS_CMD_WIDTH),
        .DEPTH (`PS_CMD_FIFO_DEPTH)
    ) cmd_fifo_i (
        .rst       (rst),
        .mclk      (mclk),
        .flush     (chn_rst),
        .we        (set_cmd && !cmd_full),
        .re        (seq_set),
        .din       (cmd_data[`PS_CMD_WIDTH-1:0]),
        .dout      (cmd_out),
        .nempty    (cmd_nempty),
        .full      (cmd_full),
        .half_full (cmd_half_full)
    );
endmodule

//--- verilog/ps_wr_buffer.sv
// four-page write buffer, host writes by address, memory side reads by page counter
module ps_wr_buffer (
    input  logic                  rst,
    input  logic                  mclk,
    input  ps_pio_pkg::buf_addr_t host_addr,
    input  logic                  host_we,
    input  ps_pio_pkg::buf_data_t host_data,
    input  ps_pio_pkg::page_t     page_in,
    input  logic                  page_set,
    input  logic                  page_next,
    input  logic                  rd,
    output ps_pio_pkg::buf_data_t rdata
);
    ps_pio_pkg::buf_data_t mem [1024];
    ps_pio_pkg::page_t     page;      // current memory-side page
    logic [7:0]            word;      // next word to send

    always_ff @(posedge rst or negedge mclk) begin
        if (!mclk) begin
            page <= '0;
            word <= '0;
        end else if (page_set) begin
            page <= page_in;
            word <= '0;
        end else if (page_next) begin
            page <= page + 2'd1;
            word <= '0;
        end else if (rd) begin
            word <= word + 8'd1;
        end
    end

    always_ff @(posedge rst) begin
        if (host_we)
            mem[host_addr] <= host_data;  // host write, same cycle
        if (rd)
            rdata <= mem[{page, word}];   // valid the cycle after rd
    end
endmodule

//--- verilog/status_gen.sv
// byte-serial status message generator, single-shot and auto-on-change modes
`include "ps_pio_defs.svh"

module status_gen (
    input  logic                rst,
    input  logic                mclk,
    input  logic                we,
    input  logic [7:0]          wd,
    input  ps_pio_pkg::status_t status,
    output logic [7:0]          ad,
    output logic                rq,
    input  logic                start
);
    ps_pio_pkg::status_state_t state;
    logic [1:0]                mode;       // 0 off, 1 once, 3 auto
    logic [5:0]                seq_num;
    logic                      pend;       // message asked by a write
    logic                      auto_chg;
    ps_pio_pkg::status_t       sent;       // payload of the last message

    assign auto_chg = (mode == 2'b11) && (status != sent);

    always_ff @(posedge rst or negedge mclk) begin
        if (!mclk) begin
            state   <= ps_pio_pkg::ST_IDLE;
            mode    <= 2'b00;
            seq_num <= '0;
            pend    <= 1'b0;
            sent    <= '0;
        end else begin
            if (we) begin
                mode    <= wd[7:6];
                seq_num <= wd[5:0];
            end
            case (state)
                ps_pio_pkg::ST_IDLE:
                    if (pend || auto_chg) begin
                        state <= ps_pio_pkg::ST_ADDR;
                        sent  <= status;                  // payload snapshot
                    end
                ps_pio_pkg::ST_ADDR:
                    if (start)
                        state <= ps_pio_pkg::ST_PAYLOAD;  // address byte taken
                default:
                    state <= ps_pio_pkg::ST_IDLE;
            endcase
            if (we)
                pend <= wd[6];                            // modes 1 and 3 send now
            else if (state == ps_pio_pkg::ST_IDLE)
                pend <= 1'b0;
        end
    end

    always_comb begin
        ad = 8'h00;
        rq = 1'b0;
        case (state)
            ps_pio_pkg::ST_ADDR: begin
                ad = `PS_STATUS_REG_ADDR;
                rq = 1'b1;                                // held until start
            end
            ps_pio_pkg::ST_PAYLOAD: ad = {seq_num, sent};
            default:                ad = 8'h00;
        endcase
    end
endmodule
